// File: Makefile
TOP = tb_ib

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f src/*.sv tb/tb_ib.sv include/ib_params.svh
	verilator --binary --timing --timescale 1ns/10ps -f files.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/10ps -f files.f --top-module ib_top

clean:
	rm -rf obj_dir

// File: files.f
+incdir+include
src/ib_pkg.sv
src/ib_ctl.sv
src/ib_slots.sv
src/dbg_inject.sv
src/ib_top.sv
tb/tb_ib.sv

// File: include/ib_params.svh
//######################################
// instruction buffer parameters
// depth, word widths and debug codes
//######################################

`ifndef IB_PARAMS_SVH
`define IB_PARAMS_SVH

// buffer geometry
`define IB_DEPTH      4
`define IB_INSTR_W    32
`define IB_PC_W       31              // pc bits 31:1

// debug command types
`define DBG_TYPE_GPR  2'd0
`define DBG_TYPE_CSR  2'd1
`define DBG_TYPE_MEM  2'd2

`define DBG_FENCE_CSR 12'h7c4         // debug-only fence csr

`endif

// File: src/dbg_inject.sv
//######################################
// debug command injector
// turns gpr/csr commands into an i0 word
// and raises the one-cycle debug flags
//######################################

`timescale 1ns/10ps
`default_nettype none

`include "ib_params.svh"

module dbg_inject (
   input  logic             clk,
   input  logic             rst,
   input  ib_pkg::dbg_cmd_t dbg_cmd,
   input  ib_pkg::instr_t   i0_instr,
   output logic             debug_valid,
   output ib_pkg::instr_t   i0_word,
   output logic             debug_wdata_rs1,
   output logic             debug_fence
);

   import ib_pkg::*;

   logic [4:0]  dreg;
   logic [11:0] dcsr;
   logic        dbg_write;
   logic        fence_hit;
   instr_t      dbg_word;

   // memory accesses are handled elsewhere
   assign debug_valid = dbg_cmd.valid & (dbg_cmd.dtype != dbg_mem);
   assign dbg_write   = debug_valid & dbg_cmd.write;

   assign dreg = dbg_cmd.addr[4:0];
   assign dcsr = dbg_cmd.addr[11:0];

   always_comb begin
      case (dbg_cmd.dtype)
         dbg_gpr: begin
            if (dbg_cmd.write) begin
               dbg_word = {20'h00006, dreg, 7'b0110011};        // or reg, x0, x0
            end else begin
               dbg_word = {12'h000, dreg, 15'b110_00000_0110011}; // or x0, reg, x0
            end
         end
         dbg_csr: begin
            if (dbg_cmd.write) begin
               dbg_word = {dcsr, 20'b00000_001_00000_1110011}; // csrrw x0, csr, x0
            end else begin
               dbg_word = {dcsr, 20'b00000_010_00000_1110011}; // csrrs x0, csr, x0
            end
         end
         default: dbg_word = '0;
      endcase
   end

   assign i0_word = debug_valid ? dbg_word : i0_instr;

   // fence csr only exists for debug mode
   assign fence_hit = dbg_write & (dbg_cmd.dtype == dbg_csr) & (dcsr == `DBG_FENCE_CSR);

   // core is halted, so the write data follows the injected entry
   always_ff @(posedge clk) begin
      if (rst) begin
         debug_wdata_rs1 <= 1'b0;
         debug_fence     <= 1'b0;
      end else begin
         debug_wdata_rs1 <= dbg_write;
         debug_fence     <= fence_hit;
      end
   end

endmodule

`default_nettype wire

// File: src/ib_ctl.sv
//######################################
// instruction buffer control
// entry valids, room check, flush and
// write/shift select generation
//######################################

`timescale 1ns/10ps
`default_nettype none

`include "ib_params.svh"

module ib_ctl (
   input  logic              clk,
   input  logic              rst,
   input  logic              i0_valid,
   input  logic              i1_valid,
   input  logic              debug_valid,
   input  logic              flush,
   input  logic              i0_decode,
   input  logic              i1_decode,
   output ib_pkg::ib_valid_t ib_valid,
   output ib_pkg::ib_sel_t   sel
);

   import ib_pkg::*;

   logic      flush_q;
   logic      i0_acc;
   logic      i1_acc;
   logic      shift1;
   logic      shift2;
   ib_valid_t shift_val;          // valids after this cycle's decode
   ib_valid_t first_free;         // one-hot, lowest empty entry after shift
   ib_valid_t valid_nxt;

   always_ff @(posedge clk) begin
      if (rst) begin
         flush_q <= 1'b0;
      end else begin
         flush_q <= flush;
      end
   end

   // room is judged on the unshifted valids
   assign i0_acc = i0_valid & ~ib_valid[`IB_DEPTH-1] & ~flush_q;
   assign i1_acc = i1_valid & ~ib_valid[`IB_DEPTH-2] & ~flush_q;

   assign shift1 = i0_decode & ~i1_decode;
   assign shift2 = i0_decode & i1_decode;

   always_comb begin
      if (shift2) begin
         shift_val = ib_valid >> 2;
      end else if (shift1) begin
         shift_val = ib_valid >> 1;
      end else begin
         shift_val = ib_valid;
      end
   end

   assign first_free = ~shift_val & {shift_val[`IB_DEPTH-2:0], 1'b1};

   always_comb begin
      // debug only ever targets entry 0
      sel.wr_i0      = first_free & {{(`IB_DEPTH-1){i0_acc}}, i0_acc | debug_valid};
      sel.wr_i1      = {first_free[`IB_DEPTH-2:0], 1'b0} & {`IB_DEPTH{i1_acc}};
      sel.from_next  = (ib_valid >> 1) & {`IB_DEPTH{shift1}};
      sel.from_next2 = (ib_valid >> 2) & {`IB_DEPTH{shift2}};
   end

   assign valid_nxt = (shift_val | sel.wr_i0 | sel.wr_i1) & ~{`IB_DEPTH{flush_q}};

   always_ff @(posedge clk) begin
      if (rst) begin
         ib_valid <= '0;
      end else begin
         ib_valid <= valid_nxt;
      end
   end

   // entries fill from the head with no holes
   a_valid_contig: assert property (@(posedge clk) disable iff (rst)
      (ib_valid_t'(ib_valid + 1'b1) & ib_valid) == '0)
      else $error("ib_ctl: valid bits not contiguous %b", ib_valid);

   a_i1_needs_i0: assert property (@(posedge clk) disable iff (rst)
      i1_valid |-> i0_valid)
      else $error("ib_ctl: i1_valid without i0_valid");

   a_dbg_empty: assert property (@(posedge clk) disable iff (rst)
      debug_valid |-> (ib_valid == '0))
      else $error("ib_ctl: debug command with buffer not empty");

endmodule

`default_nettype wire

// File: src/ib_pkg.sv
//######################################
// instruction buffer types
// payload records, debug command and
// per-entry select vectors
//######################################

`default_nettype none

`include "ib_params.svh"

package ib_pkg;

   typedef logic [`IB_INSTR_W-1:0] instr_t;

   typedef struct packed {
      logic perr;                     // parity error
      logic sbecc;                    // single-bit ecc
      logic dbecc;                    // double-bit ecc
   } ecc_err_t;

   // fetch side record that travels beside the word
   typedef struct packed {
      logic [`IB_PC_W-1:0] pc;
      logic                pc4;       // 4B inst else 2B
      logic                icaf;
      logic                icaf_second; // fault on upper half of a 4B inst
      ecc_err_t            ecc_err;
   } fetch_info_t;

   typedef enum logic [1:0] {
      dbg_gpr = `DBG_TYPE_GPR,
      dbg_csr = `DBG_TYPE_CSR,
      dbg_mem = `DBG_TYPE_MEM
   } dbg_type_e;

   typedef struct packed {
      logic        valid;
      logic        write;
      dbg_type_e   dtype;
      logic [31:0] addr;
   } dbg_cmd_t;

   typedef logic [`IB_DEPTH-1:0] ib_valid_t;

   // one bit per entry in every vector
   typedef struct packed {
      logic [`IB_DEPTH-1:0] wr_i0;
      logic [`IB_DEPTH-1:0] wr_i1;
      logic [`IB_DEPTH-1:0] from_next;
      logic [`IB_DEPTH-1:0] from_next2;
   } ib_sel_t;

endpackage

`default_nettype wire

// File: src/ib_slots.sv
//######################################
// shifting entry array
// four entries of one payload type,
// loaded or shifted by the select set
//######################################

`timescale 1ns/10ps
`default_nettype none

`include "ib_params.svh"

module ib_slots #(
   parameter type payload_t = logic [31:0]
) (
   input  logic            clk,
   input  ib_pkg::ib_sel_t sel,
   input  payload_t        i0_in,
   input  payload_t        i1_in,
   output payload_t        head0,
   output payload_t        head1
);

   payload_t ent [`IB_DEPTH];

   for (genvar n = 0; n < `IB_DEPTH; n++) begin : g_ent
      // sources that exist for this position
      localparam bit HAS_I1  = (n > 0);
      localparam bit HAS_NX1 = (n + 1 < `IB_DEPTH);
      localparam bit HAS_NX2 = (n + 2 < `IB_DEPTH);
      localparam int NX1     = HAS_NX1 ? n + 1 : n;
      localparam int NX2     = HAS_NX2 ? n + 2 : n;

      always_ff @(posedge clk) begin
         if (sel.wr_i0[n]) begin
            ent[n] <= i0_in;
         end else if (HAS_I1 && sel.wr_i1[n]) begin
            ent[n] <= i1_in;
         end else if (HAS_NX1 && sel.from_next[n]) begin
            ent[n] <= ent[NX1];
         end else if (HAS_NX2 && sel.from_next2[n]) begin
            ent[n] <= ent[NX2];
         end
      end

      // control must never pick two sources for one entry
      a_sel_onehot: assert property (@(posedge clk) disable iff ($isunknown(sel))
         $onehot0({sel.wr_i0[n], sel.wr_i1[n], sel.from_next[n], sel.from_next2[n]}))
         else $error("ib_slots: entry %0d has more than one select", n);
   end

   assign head0 = ent[0];
   assign head1 = ent[1];

endmodule

`default_nettype wire

// File: src/ib_top.sv
//######################################
// decode-side instruction buffer
// control, two entry arrays, debug path
//######################################

`timescale 1ns/10ps
`default_nettype none

module ib_top (
   input  logic                clk,
   input  logic                rst,
   input  logic                i0_valid,
   input  logic                i1_valid,
   input  ib_pkg::instr_t      i0_instr,
   input  ib_pkg::instr_t      i1_instr,
   input  ib_pkg::fetch_info_t i0_info,
   input  ib_pkg::fetch_info_t i1_info,
   input  ib_pkg::dbg_cmd_t    dbg_cmd,
   input  logic                flush,
   input  logic                i0_decode,
   input  logic                i1_decode,
   output ib_pkg::ib_valid_t   ib_valid,
   output ib_pkg::instr_t      i0_instr_d,
   output ib_pkg::instr_t      i1_instr_d,
   output ib_pkg::fetch_info_t i0_info_d,
   output ib_pkg::fetch_info_t i1_info_d,
   output logic                debug_wdata_rs1,
   output logic                debug_fence
);

   import ib_pkg::*;

   logic    debug_valid;
   instr_t  i0_word;           // fetch word or synthesized debug word
   ib_sel_t sel;

   dbg_inject u_dbg (
      .clk             (clk),
      .rst             (rst),
      .dbg_cmd         (dbg_cmd),
      .i0_instr        (i0_instr),
      .debug_valid     (debug_valid),
      .i0_word         (i0_word),
      .debug_wdata_rs1 (debug_wdata_rs1),
      .debug_fence     (debug_fence)
   );

   ib_ctl u_ctl (
      .clk         (clk),
      .rst         (rst),
      .i0_valid    (i0_valid),
      .i1_valid    (i1_valid),
      .debug_valid (debug_valid),
      .flush       (flush),
      .i0_decode   (i0_decode),
      .i1_decode   (i1_decode),
      .ib_valid    (ib_valid),
      .sel         (sel)
   );

   ib_slots #(.payload_t(instr_t)) u_instr_slots (
      .clk   (clk),
      .sel   (sel),
      .i0_in (i0_word),
      .i1_in (i1_instr),
      .head0 (i0_instr_d),
      .head1 (i1_instr_d)
   );

   // debug entries carry whatever info is on i0, as in the fetch path
   ib_slots #(.payload_t(fetch_info_t)) u_info_slots (
      .clk   (clk),
      .sel   (sel),
      .i0_in (i0_info),
      .i1_in (i1_info),
      .head0 (i0_info_d),
      .head1 (i1_info_d)
   );

endmodule

`default_nettype wire

// File: tb/ib_tests.mem
// name ctl{i0v,i1v,flush,i0dec,i1dec} dbg_cmd i0_instr i1_instr i0_info i1_info
// then expected: ib_valid head0 head1 head0_info head1_info flags{wdata_rs1,fence}
01 18 000000000 00100013 00200013 1000000120 1000000221 3 00100013 00200013 1000000120 1000000221 0
01 10 000000000 00300013 00000000 1000000330 0000000000 7 00100013 00200013 1000000120 1000000221 0
01 18 000000000 00400013 00500013 1000000428 1000000524 f 00100013 00200013 1000000120 1000000221 0
01 18 000000000 00600013 00700013 1000000622 1000000720 f 00100013 00200013 1000000120 1000000221 0
02 02 000000000 00000000 00000000 0000000000 0000000000 7 00200013 00300013 1000000221 1000000330 0
02 1b 000000000 00800013 00900013 100000083f 1000000920 3 00400013 00800013 1000000428 100000083f 0
02 1a 000000000 00a00013 00b00013 1000000a20 1000000b21 7 00800013 00a00013 100000083f 1000000a20 0
02 03 000000000 00000000 00000000 0000000000 0000000000 1 00b00013 00000000 1000000b21 0000000000 0
03 14 000000000 00c00013 00000000 1000000c20 0000000000 3 00b00013 00c00013 1000000b21 1000000c20 0
03 18 000000000 00500013 00600013 1000000524 1000000622 0 00000000 00000000 0000000000 0000000000 0
03 00 000000000 00000000 00000000 0000000000 0000000000 0 00000000 00000000 0000000000 0000000000 0
04 00 c00000005 00000000 00000000 0000000000 0000000000 1 000062b3 00000000 0000000000 0000000000 2
04 02 000000000 00000000 00000000 0000000000 0000000000 0 00000000 00000000 0000000000 0000000000 0
04 00 80000000a 00000000 00000000 0000000000 0000000000 1 00056033 00000000 0000000000 0000000000 0
04 02 000000000 00000000 00000000 0000000000 0000000000 0 00000000 00000000 0000000000 0000000000 0
04 00 900000300 00000000 00000000 0000000000 0000000000 1 30002073 00000000 0000000000 0000000000 0
04 02 000000000 00000000 00000000 0000000000 0000000000 0 00000000 00000000 0000000000 0000000000 0
04 00 e00001000 00000000 00000000 0000000000 0000000000 0 00000000 00000000 0000000000 0000000000 0
05 00 d000007c4 00000000 00000000 0000000000 0000000000 1 7c401073 00000000 0000000000 0000000000 3
05 02 000000000 00000000 00000000 0000000000 0000000000 0 00000000 00000000 0000000000 0000000000 0
05 00 d000007c5 00000000 00000000 0000000000 0000000000 1 7c501073 00000000 0000000000 0000000000 2
05 02 000000000 00000000 00000000 0000000000 0000000000 0 00000000 00000000 0000000000 0000000000 0

// File: tb/tb_ib.sv
//######################################
// instruction buffer testbench
// one stimulus/expect vector per cycle,
// read from the vector file
//######################################

`timescale 1ns/10ps
`default_nettype none

module tb_ib;

   import ib_pkg::*;

   localparam int NUM_VEC = 22;
   localparam int NUM_COL = 13;             // values per vector line
   localparam int MAX_CYC = NUM_VEC + 20;   // reset and slack fit in the margin

   logic        clk;
   logic        rst;
   logic        i0_valid;
   logic        i1_valid;
   instr_t      i0_instr;
   instr_t      i1_instr;
   fetch_info_t i0_info;
   fetch_info_t i1_info;
   dbg_cmd_t    dbg_cmd;
   logic        flush;
   logic        i0_decode;
   logic        i1_decode;
   ib_valid_t   ib_valid;
   instr_t      i0_instr_d;
   instr_t      i1_instr_d;
   fetch_info_t i0_info_d;
   fetch_info_t i1_info_d;
   logic        debug_wdata_rs1;
   logic        debug_fence;

   logic [39:0] tv [0:NUM_VEC*NUM_COL-1];
   int          cycles;

   ib_top UUT (
      .clk             (clk),
      .rst             (rst),
      .i0_valid        (i0_valid),
      .i1_valid        (i1_valid),
      .i0_instr        (i0_instr),
      .i1_instr        (i1_instr),
      .i0_info         (i0_info),
      .i1_info         (i1_info),
      .dbg_cmd         (dbg_cmd),
      .flush           (flush),
      .i0_decode       (i0_decode),
      .i1_decode       (i1_decode),
      .ib_valid        (ib_valid),
      .i0_instr_d      (i0_instr_d),
      .i1_instr_d      (i1_instr_d),
      .i0_info_d       (i0_info_d),
      .i1_info_d       (i1_info_d),
      .debug_wdata_rs1 (debug_wdata_rs1),
      .debug_fence     (debug_fence)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic string test_name(input logic [7:0] code);
      case (code)
         8'h01:   return "fill";
         8'h02:   return "shift";
         8'h03:   return "flush";
         8'h04:   return "debug";
         8'h05:   return "fence";
         default: return "unknown";
      endcase
   endfunction

   task automatic check_valid(input string tname, input ib_valid_t exp,
                              input ib_valid_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: ib_valid expected %b actual %b", tname, exp, act);
         $display("RESULT: FAIL");
         $fatal(1, "ib_valid mismatch");
      end
   endtask

   task automatic check_instr(input string tname, input string what,
                              input instr_t exp, input instr_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: %s expected %h actual %h", tname, what, exp, act);
         $display("RESULT: FAIL");
         $fatal(1, "instruction word mismatch");
      end
   endtask

   task automatic check_info(input string tname, input string what,
                             input fetch_info_t exp, input fetch_info_t act);
      if (act !== exp) begin
         $display("[ERROR] %s: %s expected %h actual %h", tname, what, exp, act);
         $display("RESULT: FAIL");
         $fatal(1, "fetch info mismatch");
      end
   endtask

   task automatic check_flag(input string tname, input string what,
                             input logic exp, input logic act);
      if (act !== exp) begin
         $display("[ERROR] %s: %s expected %b actual %b", tname, what, exp, act);
         $display("RESULT: FAIL");
         $fatal(1, "debug flag mismatch");
      end
   endtask

   // ctl column is {i0_valid, i1_valid, flush, i0_decode, i1_decode}
   task automatic apply_vector(input int base);
      i0_valid  = tv[base+1][4];
      i1_valid  = tv[base+1][3];
      flush     = tv[base+1][2];
      i0_decode = tv[base+1][1];
      i1_decode = tv[base+1][0];
      dbg_cmd   = tv[base+2][35:0];
      i0_instr  = tv[base+3][31:0];
      i1_instr  = tv[base+4][31:0];
      i0_info   = tv[base+5][36:0];
      i1_info   = tv[base+6][36:0];
   endtask

   task automatic compare_outputs(input int base);
      string     tname;
      ib_valid_t exp_valid;
      tname     = $sformatf("%s (vector %0d)", test_name(tv[base][7:0]), base / NUM_COL);
      exp_valid = tv[base+7][3:0];
      check_valid(tname, exp_valid, ib_valid);
      // empty entries hold stale data
      if (exp_valid[0]) begin
         check_instr(tname, "head0 word", tv[base+8][31:0], i0_instr_d);
         check_info(tname, "head0 info", tv[base+10][36:0], i0_info_d);
      end
      if (exp_valid[1]) begin
         check_instr(tname, "head1 word", tv[base+9][31:0], i1_instr_d);
         check_info(tname, "head1 info", tv[base+11][36:0], i1_info_d);
      end
      check_flag(tname, "debug_wdata_rs1", tv[base+12][1], debug_wdata_rs1);
      check_flag(tname, "debug_fence", tv[base+12][0], debug_fence);
   endtask

   initial begin
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles >= MAX_CYC) begin
            $display("timeout: vectors not finished after %0d cycles", MAX_CYC);
            $display("RESULT: FAIL");
            $fatal(1, "simulation timeout");
         end
      end
   end

   initial begin
      rst       = 1'b1;
      i0_valid  = 1'b0;
      i1_valid  = 1'b0;
      i0_instr  = '0;
      i1_instr  = '0;
      i0_info   = '0;
      i1_info   = '0;
      dbg_cmd   = '0;
      flush     = 1'b0;
      i0_decode = 1'b0;
      i1_decode = 1'b0;
      $readmemh("tb/ib_tests.mem", tv);
      if (tv[0] == '0 || $isunknown(tv[0])) begin
         $display("the vector file tb/ib_tests.mem is missing or empty");
         $display("RESULT: FAIL");
         $fatal(1, "no stimulus");
      end else begin
         repeat (10) @(posedge clk);
         @(negedge clk);
         rst = 1'b0;
         for (int v = 0; v < NUM_VEC; v++) begin
            apply_vector(v * NUM_COL);       // drive on falling edge
            @(negedge clk);
            compare_outputs(v * NUM_COL);    // state after the rising edge
         end
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire
